/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= wh_inject_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+src
src/wh_pkt_pkg.sv
src/wh_ctrl_pkg.sv
src/wh_adapter_in.sv
src/wh_flit_arbiter.sv
src/wh_inject_top.sv
tests/wh_inject_props.sv
tests/wh_inject_tb.sv

/* src/wh_adapter_in.sv */
`timescale 1ns/1ps

`include "wh_params.svh"

module wh_adapter_in (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  wh_pkt_pkg::wh_packet_s packet_i,
  input  logic                   packet_v_i,
  output logic                   packet_ready_o,

  output wh_pkt_pkg::wh_link_s   link_o,
  input  logic                   link_ready_i
);

  ////////////////////////////////
  // State and datapath
  ////////////////////////////////

  wh_ctrl_pkg::wh_adapter_state_e state_q;

  logic [`WH_MAX_FLITS*`WH_FLIT_WIDTH-1:0] shift_q;   // Current flit in low bits
  logic [`WH_LEN_WIDTH-1:0]                len_q;
  logic [`WH_FLIT_CNT_WIDTH-1:0]           cnt_q;     // Flits already sent

  logic accept;
  logic flit_xfer;
  logic last_flit;

  // Ready is a function of state only
  assign packet_ready_o = (state_q == wh_ctrl_pkg::ADP_IDLE);

  assign accept    = packet_v_i & packet_ready_o;
  assign flit_xfer = link_o.v & link_ready_i;
  assign last_flit = (`WH_LEN_WIDTH'(cnt_q) == len_q);

  assign link_o.v    = (state_q == wh_ctrl_pkg::ADP_SEND);
  assign link_o.data = shift_q[`WH_FLIT_WIDTH-1:0];

  ////////////////////////////////
  // Control FSM
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= wh_ctrl_pkg::ADP_IDLE;
      cnt_q   <= '0;
      len_q   <= '0;
    end else begin
      case (state_q)
        wh_ctrl_pkg::ADP_IDLE: begin
          if (accept) begin
            state_q <= wh_ctrl_pkg::ADP_SEND;
            cnt_q   <= '0;
            len_q   <= packet_i.len;   // Flits after the head
          end
        end
        wh_ctrl_pkg::ADP_SEND: begin
          if (flit_xfer) begin
            if (last_flit) begin
              state_q <= wh_ctrl_pkg::ADP_IDLE;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= wh_ctrl_pkg::ADP_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////
  // Shift register
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= packet_i;                           // Flit 0 valid next cycle
    end else if (flit_xfer) begin
      shift_q <= shift_q >> `WH_FLIT_WIDTH;          // Bring next flit down
    end
  end

endmodule

/* src/wh_ctrl_pkg.sv */
package wh_ctrl_pkg;

  ////////////////////////////////
  // Input adapter FSM
  ////////////////////////////////

  typedef enum logic {
    ADP_IDLE = 1'b0,  // Waiting for a packet
    ADP_SEND = 1'b1   // Shifting flits out
  } wh_adapter_state_e;

  ////////////////////////////////
  // Flit arbiter FSM
  ////////////////////////////////

  typedef enum logic {
    ARB_IDLE   = 1'b0,  // Free to pick a head flit
    ARB_LOCKED = 1'b1   // Body flits of the granted packet
  } wh_arb_state_e;

endpackage

/* src/wh_flit_arbiter.sv */
`timescale 1ns/1ps

`include "wh_params.svh"

module wh_flit_arbiter (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  input  wh_pkt_pkg::wh_link_s in0_i,
  output logic                 in0_ready_o,
  input  wh_pkt_pkg::wh_link_s in1_i,
  output logic                 in1_ready_o,

  output wh_pkt_pkg::wh_link_s link_o,
  input  logic                 link_ready_i
);

  wh_ctrl_pkg::wh_arb_state_e state_q;

  logic                     grant_q;   // Input owning the link
  logic                     prio_q;    // Preferred input on a tie
  logic                     pend_q;    // Head offered but not yet taken
  logic [`WH_LEN_WIDTH-1:0] rem_q;     // Body flits still to pass

  logic                  sel;
  logic                  xfer;
  wh_pkt_pkg::wh_head_s  head;

  ////////////////////////////////
  // Select and route
  ////////////////////////////////

  always_comb begin
    if (state_q == wh_ctrl_pkg::ARB_LOCKED || pend_q) begin
      sel = grant_q;
    end else if (in0_i.v && in1_i.v) begin
      sel = prio_q;
    end else begin
      sel = in1_i.v;   // Lone valid input wins
    end
  end

  assign link_o      = sel ? in1_i : in0_i;
  assign in0_ready_o = link_ready_i & ~sel;
  assign in1_ready_o = link_ready_i & sel;

  assign xfer = link_o.v & link_ready_i;
  assign head = link_o.data;

  ////////////////////////////////
  // Wormhole lock
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= wh_ctrl_pkg::ARB_IDLE;
      grant_q <= 1'b0;
      prio_q  <= 1'b0;
      pend_q  <= 1'b0;
      rem_q   <= '0;
    end else begin
      case (state_q)
        wh_ctrl_pkg::ARB_IDLE: begin
          if (xfer) begin
            pend_q <= 1'b0;
            if (head.len != '0) begin
              state_q <= wh_ctrl_pkg::ARB_LOCKED;
              grant_q <= sel;
              rem_q   <= head.len;
            end else begin
              prio_q <= ~sel;   // Single flit packet done
            end
          end else if (link_o.v) begin
            // Keep an offered head stable under back-pressure
            pend_q  <= 1'b1;
            grant_q <= sel;
          end
        end
        wh_ctrl_pkg::ARB_LOCKED: begin
          if (xfer) begin
            rem_q <= rem_q - 1'b1;
            if (rem_q == `WH_LEN_WIDTH'(1)) begin
              state_q <= wh_ctrl_pkg::ARB_IDLE;
              prio_q  <= ~grant_q;   // Tail passed
            end
          end
        end
        default: begin
          state_q <= wh_ctrl_pkg::ARB_IDLE;
        end
      endcase
    end
  end

endmodule

/* src/wh_inject_top.sv */
`timescale 1ns/1ps

module wh_inject_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  wh_pkt_pkg::wh_packet_s pkt0_i,
  input  logic                   pkt0_v_i,
  output logic                   pkt0_ready_o,

  input  wh_pkt_pkg::wh_packet_s pkt1_i,
  input  logic                   pkt1_v_i,
  output logic                   pkt1_ready_o,

  output wh_pkt_pkg::wh_link_s   link_o,
  input  logic                   link_ready_i
);

  ////////////////////////////////
  // Client flit streams
  ////////////////////////////////

  wh_pkt_pkg::wh_link_s link0;
  wh_pkt_pkg::wh_link_s link1;
  logic                 link0_ready;
  logic                 link1_ready;

  wh_adapter_in u_adapter0 (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .packet_i       (pkt0_i),
    .packet_v_i     (pkt0_v_i),
    .packet_ready_o (pkt0_ready_o),
    .link_o         (link0),
    .link_ready_i   (link0_ready)
  );

  wh_adapter_in u_adapter1 (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .packet_i       (pkt1_i),
    .packet_v_i     (pkt1_v_i),
    .packet_ready_o (pkt1_ready_o),
    .link_o         (link1),
    .link_ready_i   (link1_ready)
  );

  // Merge onto the outgoing link
  wh_flit_arbiter u_arbiter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .in0_i        (link0),
    .in0_ready_o  (link0_ready),
    .in1_i        (link1),
    .in1_ready_o  (link1_ready),
    .link_o       (link_o),
    .link_ready_i (link_ready_i)
  );

endmodule

/* src/wh_params.svh */
`ifndef WH_PARAMS_SVH
`define WH_PARAMS_SVH

////////////////////////////////
// Link and packet widths
////////////////////////////////

`define WH_FLIT_WIDTH     16
`define WH_CORD_WIDTH     4
`define WH_LEN_WIDTH      3
`define WH_PAYLOAD_WIDTH  57

// Whole packet, one word
`define WH_PACKET_WIDTH   (`WH_PAYLOAD_WIDTH + `WH_LEN_WIDTH + `WH_CORD_WIDTH)

////////////////////////////////
// Derived flit counts
////////////////////////////////

`define WH_MAX_FLITS      ((`WH_PACKET_WIDTH + `WH_FLIT_WIDTH - 1) / `WH_FLIT_WIDTH)
`define WH_FLIT_CNT_WIDTH 2   // Enough for WH_MAX_FLITS - 1

// Payload bits that share flit 0 with the header fields
`define WH_HEAD_PAYLOAD_WIDTH (`WH_FLIT_WIDTH - `WH_LEN_WIDTH - `WH_CORD_WIDTH)

`endif

/* src/wh_pkt_pkg.sv */
`include "wh_params.svh"

package wh_pkt_pkg;

  ////////////////////////////////
  // Packet as offered by a client
  ////////////////////////////////

  typedef struct packed {
    logic [`WH_PAYLOAD_WIDTH-1:0] payload;
    logic [`WH_LEN_WIDTH-1:0]     len;    // Flits after the head
    logic [`WH_CORD_WIDTH-1:0]    cord;   // Destination, low bits
  } wh_packet_s;

  // Flit 0 read as a header
  typedef struct packed {
    logic [`WH_HEAD_PAYLOAD_WIDTH-1:0] payload;
    logic [`WH_LEN_WIDTH-1:0]          len;
    logic [`WH_CORD_WIDTH-1:0]         cord;
  } wh_head_s;

  ////////////////////////////////
  // One link channel
  ////////////////////////////////

  typedef struct packed {
    logic                      v;
    logic [`WH_FLIT_WIDTH-1:0] data;
  } wh_link_s;

endpackage

/* tests/wh_inject_props.sv */
`timescale 1ns/1ps

`include "wh_params.svh"

module wh_inject_props (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input wh_pkt_pkg::wh_packet_s pkt0_i,
  input logic                   pkt0_v_i,
  input wh_pkt_pkg::wh_packet_s pkt1_i,
  input logic                   pkt1_v_i,
  input wh_pkt_pkg::wh_link_s   link_i,
  input logic                   link_ready_i
);

  //////////////////////////////
  // Link handshake
  //////////////////////////////

  a_link_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (link_i.v && !link_ready_i) |=> (link_i.v && $stable(link_i.data))
  ) else $error("Output flit dropped or changed under back-pressure");

  a_reset_idle: assert property (
    @(posedge clk_i) $rose(arst_n_i) |-> !link_i.v
  ) else $error("Output valid high right after reset release");

  //////////////////////////////
  // Packet inputs
  //////////////////////////////

  a_pkt0_len: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pkt0_v_i |-> (pkt0_i.len <= `WH_LEN_WIDTH'(`WH_MAX_FLITS - 1))
  ) else $error("Input 0 packet longer than the flit budget");

  a_pkt1_len: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pkt1_v_i |-> (pkt1_i.len <= `WH_LEN_WIDTH'(`WH_MAX_FLITS - 1))
  ) else $error("Input 1 packet longer than the flit budget");

endmodule

bind wh_inject_top wh_inject_props u_props (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .pkt0_i       (pkt0_i),
  .pkt0_v_i     (pkt0_v_i),
  .pkt1_i       (pkt1_i),
  .pkt1_v_i     (pkt1_v_i),
  .link_i       (link_o),
  .link_ready_i (link_ready_i)
);

/* tests/wh_inject_tb.sv */
`timescale 1ns/1ps

`include "wh_params.svh"

module wh_inject_tb;

  localparam int LEN_CYCLE    = 0;
  localparam int LEN_RANDOM   = 1;
  localparam int LEN_FULL     = 2;
  localparam int READY_ALWAYS = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_STALL  = 2;
  localparam int ACCEPT_LIMIT = 200;
  localparam int DRAIN_LIMIT  = 2000;

  //////////////////////////////
  // DUT and stimulus signals
  //////////////////////////////

  logic                   clk = 1'b0;
  logic                   arst_n;
  wh_pkt_pkg::wh_packet_s pkt [2];
  logic                   pkt_v [2];
  logic                   pkt_ready [2];
  wh_pkt_pkg::wh_link_s   link;
  logic                   link_ready;

  logic [31:0] rng [3] = '{32'd20825, 32'd20825 ^ 32'h9e37_79b9, 32'd20825 ^ 32'h7f4a_7c15};

  wh_pkt_pkg::wh_packet_s exp_q0 [$];   // Accepted at input 0
  wh_pkt_pkg::wh_packet_s exp_q1 [$];
  int                     src_log [$];  // Source of each output packet

  int    acc_cnt [2];
  int    seq_no [2];
  int    out_cnt;
  int    mon_idx;                       // Flits seen of current packet
  int    ready_mode;
  string test_name;

  always #5 clk = ~clk;

  wh_inject_top u_dut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .pkt0_i       (pkt[0]),
    .pkt0_v_i     (pkt_v[0]),
    .pkt0_ready_o (pkt_ready[0]),
    .pkt1_i       (pkt[1]),
    .pkt1_v_i     (pkt_v[1]),
    .pkt1_ready_o (pkt_ready[1]),
    .link_o       (link),
    .link_ready_i (link_ready)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One stream per process
  function automatic logic [31:0] next_random(input int k);
    rng[k] = xorshift32(rng[k]);
    return rng[k];
  endfunction

  // Expected flits: len+1 slices from bit 0
  function automatic logic [`WH_MAX_FLITS-1:0][`WH_FLIT_WIDTH-1:0] packet_to_flits(
    input wh_pkt_pkg::wh_packet_s p
  );
    logic [`WH_MAX_FLITS*`WH_FLIT_WIDTH-1:0]        bits;
    logic [`WH_MAX_FLITS-1:0][`WH_FLIT_WIDTH-1:0]   flits;
    int                                             k;
    bits  = p;
    flits = '0;
    for (k = 0; k <= int'(p.len) && k < `WH_MAX_FLITS; k++) begin
      flits[k] = bits[k*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH];
    end
    return flits;
  endfunction

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("FAILED %s expected %h actual %h", name, exp_val, act_val);
      stop_on_error();
    end
  endtask

  task automatic drive_source(input int src, input int n_pkts, input int idle_pct,
                              input int len_mode);
    int                     sent;
    int                     wait_cycles;
    logic                   offering;
    logic                   taken;
    logic [31:0]            r0;
    logic [31:0]            r1;
    logic [2:0]             len;
    wh_pkt_pkg::wh_packet_s p;
    sent        = 0;
    wait_cycles = 0;
    offering    = 1'b0;
    taken       = 1'b0;
    while (sent < n_pkts) begin
      @(negedge clk);
      if (taken) begin   // Handshake on the last rising edge
        offering = 1'b0;
        taken    = 1'b0;
        sent++;
      end
      if (!offering && sent < n_pkts && (next_random(src) % 100) >= idle_pct) begin
        r0 = next_random(src);
        r1 = next_random(src);
        case (len_mode)
          LEN_CYCLE:  len = 3'(sent % 4);
          LEN_RANDOM: len = {1'b0, r1[9:8]};
          default:    len = 3'd3;
        endcase
        p.cord      = {src[0], r1[12:10]};   // Source visible in the head flit
        p.len       = len;
        p.payload   = {src[0], 16'(seq_no[src]), r0, r1[7:0]};
        pkt[src]    = p;
        pkt_v[src]  = 1'b1;
        offering    = 1'b1;
        wait_cycles = 0;
        seq_no[src]++;
      end else if (!offering) begin
        pkt_v[src] = 1'b0;
      end
      if (offering) begin
        // Ready only moves on a rising edge
        if (pkt_ready[src]) begin
          taken = 1'b1;
          acc_cnt[src]++;
          if (src == 0) begin
            exp_q0.push_back(pkt[src]);
          end else begin
            exp_q1.push_back(pkt[src]);
          end
        end else begin
          wait_cycles++;
          if (wait_cycles > ACCEPT_LIMIT) begin
            $display("Timeout: source %0d packet was never accepted in %s", src, test_name);
            stop_on_error();
          end
        end
      end
    end
    pkt_v[src] = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (out_cnt != acc_cnt[0] + acc_cnt[1] || mon_idx != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        $display("Timeout: traffic of %s did not drain", test_name);
        stop_on_error();
      end
    end
  endtask

  //////////////////////////////
  // Link ready and monitor
  //////////////////////////////

  initial begin : ready_driver
    int stall_left;
    int stalled_pkt;
    stall_left  = 0;
    stalled_pkt = -1;
    link_ready  = 1'b0;
    forever begin
      @(negedge clk);
      case (ready_mode)
        READY_ALWAYS: link_ready = 1'b1;
        READY_RANDOM: link_ready = (next_random(2) % 10) < 7;
        default: begin
          if (stall_left > 0) begin
            link_ready = 1'b0;
            stall_left--;
          end else if (mon_idx == 2 && stalled_pkt != out_cnt) begin
            // Hold off in the middle of the packet
            stalled_pkt = out_cnt;
            stall_left  = 2 + int'(next_random(2) % 10);
            link_ready  = 1'b0;
          end else begin
            link_ready = 1'b1;
          end
        end
      endcase
    end
  end

  initial begin : monitor
    wh_pkt_pkg::wh_packet_s                       cur;
    wh_pkt_pkg::wh_head_s                         head;
    logic [`WH_MAX_FLITS-1:0][`WH_FLIT_WIDTH-1:0] exp_flits;
    int                                           cur_src;
    cur_src   = 0;
    cur       = '0;
    exp_flits = '0;
    forever begin
      @(posedge clk);
      if (arst_n && link.v && link_ready) begin
        if (mon_idx == 0) begin
          head    = link.data;
          cur_src = int'(head.cord[`WH_CORD_WIDTH-1]);
          if ((cur_src == 0 && exp_q0.size() == 0) || (cur_src == 1 && exp_q1.size() == 0)) begin
            $display("Head flit from source %0d with no packet outstanding in %s",
                     cur_src, test_name);
            stop_on_error();
          end
          cur       = (cur_src == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
          exp_flits = packet_to_flits(cur);
        end
        check_value($sformatf("%s flit %0d of packet %0d", test_name, mon_idx, out_cnt),
                    64'(exp_flits[mon_idx]), 64'(link.data));
        if (mon_idx == int'(cur.len)) begin
          out_cnt++;
          src_log.push_back(cur_src);
          mon_idx = 0;
        end else begin
          mon_idx++;
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    int i;
    out_cnt    = 0;
    mon_idx    = 0;
    acc_cnt    = '{0, 0};
    seq_no     = '{0, 0};
    ready_mode = READY_ALWAYS;
    test_name  = "reset";
    arst_n     = 1'b0;
    pkt[0]     = '0;
    pkt[1]     = '0;
    pkt_v[0]   = 1'b0;
    pkt_v[1]   = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_value("reset pkt0 ready", 64'(1), 64'(pkt_ready[0]));
    check_value("reset pkt1 ready", 64'(1), 64'(pkt_ready[1]));
    check_value("reset link valid", 64'(0), 64'(link.v));

    test_name = "single_source";
    drive_source(0, 8, 0, LEN_CYCLE);
    drive_source(1, 8, 0, LEN_CYCLE);
    wait_drain();

    test_name  = "random_mix";
    ready_mode = READY_RANDOM;
    fork
      drive_source(0, 40, 30, LEN_RANDOM);
      drive_source(1, 40, 30, LEN_RANDOM);
    join
    wait_drain();

    test_name  = "round_robin";
    ready_mode = READY_ALWAYS;
    src_log.delete();
    fork
      drive_source(0, 12, 0, LEN_RANDOM);
      drive_source(1, 12, 0, LEN_RANDOM);
    join
    wait_drain();
    check_value("round_robin packets", 64'(24), 64'(src_log.size()));
    for (i = 1; i < src_log.size(); i++) begin
      check_value($sformatf("round_robin source of packet %0d", i),
                  64'(1 - src_log[i-1]), 64'(src_log[i]));
    end

    test_name  = "mid_packet_stall";
    ready_mode = READY_STALL;
    fork
      drive_source(0, 4, 0, LEN_FULL);
      drive_source(1, 4, 0, LEN_FULL);
    join
    wait_drain();

    // Link quiet and both clients free once everything has left
    test_name = "drain_count";
    check_value("drain_count link valid", 64'(0), 64'(link.v));
    check_value("drain_count pkt0 ready", 64'(1), 64'(pkt_ready[0]));
    check_value("drain_count pkt1 ready", 64'(1), 64'(pkt_ready[1]));

    $display("Finished with no errors");
    $finish;
  end

endmodule
